/* logic/rvIsaPkg.sv */
// RV32I encoding package: opcode values, instruction field types and funct codes.
package rvIsaPkg;

	// Instruction field types.
	typedef logic [6:0] opcodeT;
	typedef logic [2:0] funct3T;
	typedef logic [6:0] funct7T;

	// Major opcodes of the supported subset.
	localparam opcodeT opR      = 7'b0110011; // Register-register ALU.
	localparam opcodeT opImm    = 7'b0010011; // Register-immediate ALU.
	localparam opcodeT opLoad   = 7'b0000011;
	localparam opcodeT opStore  = 7'b0100011;
	localparam opcodeT opBranch = 7'b1100011;
	localparam opcodeT opLui    = 7'b0110111;
	localparam opcodeT opAuipc  = 7'b0010111;

	// Funct3 codes of the ALU group, shared by R-type and immediate forms.
	localparam funct3T f3AddSub = 3'b000; // Sub only for R-type with bit 30 set.
	localparam funct3T f3Sll    = 3'b001;
	localparam funct3T f3Slt    = 3'b010;
	localparam funct3T f3Sltu   = 3'b011;
	localparam funct3T f3Xor    = 3'b100;
	localparam funct3T f3SrlSra = 3'b101; // Bit 30 picks the arithmetic shift.
	localparam funct3T f3Or     = 3'b110;
	localparam funct3T f3And    = 3'b111;

	// Funct3 codes of the memory and branch instructions.
	localparam funct3T f3Lw  = 3'b010; // Word load.
	localparam funct3T f3Sw  = 3'b010; // Word store.
	localparam funct3T f3Beq = 3'b000;

	// Funct7 codes.
	localparam funct7T f7Base = 7'b0000000;
	localparam funct7T f7Alt  = 7'b0100000; // Sets bit 30 for sub and sra.

	// Bit positions of the fields inside an instruction word.
	localparam int opcodeLsb = 0;
	localparam int rdLsb     = 7;
	localparam int funct3Lsb = 12;
	localparam int rs1Lsb    = 15;
	localparam int rs2Lsb    = 20;
	localparam int funct7Lsb = 25;

	// Instruction slot of the reset vector and the byte step between slots.
	localparam int instrBytes = 4;

	// Register numbers with a fixed role.
	localparam logic [4:0] regZero = 5'd0; // Hardwired zero.

endpackage

/* logic/corePkg.sv */
// Core datapath package: word and index types, ALU codes and operand selection.
package corePkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] wordT; // Data or byte address.
	typedef logic [4:0]      regIdxT;

	// ALU operation codes.
	typedef logic [3:0] aluOpT;

	localparam aluOpT aluAdd  = 4'd0;
	localparam aluOpT aluSub  = 4'd1;
	localparam aluOpT aluAnd  = 4'd2;
	localparam aluOpT aluOr   = 4'd3;
	localparam aluOpT aluXor  = 4'd4;
	localparam aluOpT aluSlt  = 4'd5; // Signed compare.
	localparam aluOpT aluSltu = 4'd6; // Unsigned compare.
	localparam aluOpT aluSll  = 4'd7;
	localparam aluOpT aluSrl  = 4'd8;
	localparam aluOpT aluSra  = 4'd9;

	// First ALU operand source.
	typedef logic [1:0] aSelT;

	localparam aSelT aSelReg  = 2'd0; // Register rs1.
	localparam aSelT aSelPc   = 2'd1; // Program counter, for auipc.
	localparam aSelT aSelZero = 2'd2; // Zero, for lui.

	// Address of the first instruction after reset.
	localparam wordT resetPc = '0;

endpackage

/* logic/ctrlIf.sv */
// Decoded control bundle passed from the instruction decoder to the datapath.
interface ctrlIf import corePkg::*; ();

	logic  regWrite;  // Write rd at the clock edge.
	logic  memRead;
	logic  memWrite;
	logic  memToReg;  // Write back load data instead of the ALU result.
	logic  aluSrcImm; // Second ALU operand is the immediate.
	logic  branch;    // Instruction is beq.
	aSelT  aSel;
	aluOpT aluOp;

	modport dec (
		output regWrite, memRead, memWrite, memToReg,
		output aluSrcImm, branch, aSel, aluOp
	);

	// Levels are valid for the whole cycle of the current instruction.
	modport dp (
		input regWrite, memRead, memWrite, memToReg,
		input aluSrcImm, branch, aSel, aluOp
	);

endinterface

/* logic/instrDecoder.sv */
// Instruction decoder: main control from the opcode and ALU operation from funct3 and bit 30.
module instrDecoder import rvIsaPkg::*, corePkg::*; (
	input wordT instr,
	ctrlIf.dec  ctl
);

	opcodeT opcode;
	funct3T funct3;
	logic   alt;   // Instruction bit 30.
	aluOpT  aluFn; // ALU operation of the R-type and immediate group.

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign alt    = instr[30];

	// ALU function decode. Immediate forms have no subtract.
	always_comb begin
		case (funct3)
			f3AddSub: aluFn = (opcode == opR && alt) ? aluSub : aluAdd;
			f3Sll:    aluFn = aluSll;
			f3Slt:    aluFn = aluSlt;
			f3Sltu:   aluFn = aluSltu;
			f3Xor:    aluFn = aluXor;
			f3SrlSra: aluFn = alt ? aluSra : aluSrl;
			f3Or:     aluFn = aluOr;
			default:  aluFn = aluAnd;
		endcase
	end

	// Main decode. Defaults leave unknown opcodes without side effects.
	always_comb begin
		ctl.regWrite  = 1'b0;
		ctl.memRead   = 1'b0;
		ctl.memWrite  = 1'b0;
		ctl.memToReg  = 1'b0;
		ctl.aluSrcImm = 1'b0;
		ctl.branch    = 1'b0;
		ctl.aSel      = aSelReg;
		ctl.aluOp     = aluAdd;
		case (opcode)
			opR: begin
				ctl.regWrite = 1'b1;
				ctl.aluOp    = aluFn;
			end
			opImm: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aluOp     = aluFn;
			end
			opLoad: begin
				ctl.regWrite  = 1'b1;
				ctl.memRead   = 1'b1;
				ctl.memToReg  = 1'b1;
				ctl.aluSrcImm = 1'b1; // Address is rs1 plus offset.
			end
			opStore: begin
				ctl.memWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
			end
			opBranch: begin
				ctl.branch = 1'b1;
				ctl.aluOp  = aluSub; // Zero flag signals equal operands.
			end
			opLui: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aSel      = aSelZero;
			end
			opAuipc: begin
				ctl.regWrite  = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.aSel      = aSelPc;
			end
			default: ;
		endcase
	end

endmodule

/* logic/immGen.sv */
// Immediate generator: sign-extended I, S and B immediates and the upper U immediate.
module immGen import rvIsaPkg::*, corePkg::*; (
	input  wordT instr,
	output wordT imm
);

	opcodeT opcode;
	logic   sign;

	assign opcode = instr[6:0];
	assign sign   = instr[31];

	always_comb begin
		case (opcode)
			// I format.
			opImm, opLoad: imm = {{20{sign}}, instr[31:20]};
			// S format splits the offset around rs2.
			opStore: imm = {{20{sign}}, instr[31:25], instr[11:7]};
			opBranch: begin
				// B format, bit 0 is always zero.
				imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			opLui, opAuipc: imm = {instr[31:12], 12'b0}; // Upper 20 bits.
			default: imm = '0;
		endcase
	end

endmodule

/* logic/regBank.sv */
// Register file: 32 words, two combinational read ports, one clocked write port, x0 fixed at zero.
module regBank import corePkg::*; (
	input  logic   CLK,
	input  logic   rstN,
	input  logic   wrEn,
	input  regIdxT rdAddrA,
	input  regIdxT rdAddrB,
	input  regIdxT wrAddr,
	input  wordT   wrData,
	output wordT   rdDataA,
	output wordT   rdDataB
);

	wordT regs [1:31]; // No storage behind x0.

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0; // Programs start from known zeros.
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

/* logic/alu.sv */
// 32-bit ALU with ten operations and a zero flag for the branch compare.
module alu import corePkg::*; (
	input  wordT  a,
	input  wordT  b,
	input  aluOpT op,
	output wordT  result,
	output logic  zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // Only the low five bits shift.

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluXor:  result = a ^ b;
			aluSlt:  result = wordT'($signed(a) < $signed(b));
			aluSltu: result = wordT'(a < b);
			aluSll:  result = a << shamt;
			aluSrl:  result = a >> shamt;
			aluSra:  result = wordT'($signed(a) >>> shamt); // Sign fills from the left.
			default: result = '0;
		endcase
	end

	// Equal operands after a subtract.
	assign zero = (result == '0);

endmodule

/* logic/rvCore.sv */
// Single-cycle RV32I core: program counter, operand and write-back muxes, memory strobes.
module rvCore import corePkg::*; (
	input  logic CLK,
	input  logic rstN,
	output wordT iaddr,
	input  wordT idata,
	output wordT daddr,
	output wordT ddataW,
	output logic dRead,
	output logic dWrite,
	input  wordT ddataR
);

	wordT   pc;
	wordT   pcPlus4;
	wordT   pcPlusImm;
	wordT   nextPc;
	wordT   imm;
	wordT   rdDataA;
	wordT   rdDataB;
	wordT   aluA;
	wordT   aluB;
	wordT   aluResult;
	wordT   wbData;
	logic   aluZero;
	logic   takeBranch;
	logic   regWen;
	regIdxT rs1;
	regIdxT rs2;
	regIdxT rd;

	ctrlIf ctl ();

	instrDecoder decoder_i (.instr(idata), .ctl(ctl.dec));

	immGen immGen_i (.instr(idata), .imm(imm));

	assign rs1 = idata[19:15];
	assign rs2 = idata[24:20];
	assign rd  = idata[11:7];

	regBank regBank_i (
		.CLK(CLK),
		.rstN(rstN),
		.wrEn(regWen),
		.rdAddrA(rs1),
		.rdAddrB(rs2),
		.wrAddr(rd),
		.wrData(wbData),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	// First operand: rs1, the PC for auipc or zero for lui.
	always_comb begin
		case (ctl.aSel)
			aSelPc:   aluA = pc;
			aSelZero: aluA = '0;
			default:  aluA = rdDataA;
		endcase
	end

	assign aluB = ctl.aluSrcImm ? imm : rdDataB;

	alu alu_i (.a(aluA), .b(aluB), .op(ctl.aluOp), .result(aluResult), .zero(aluZero));

	assign wbData = ctl.memToReg ? ddataR : aluResult;
	assign regWen = ctl.regWrite & rstN;

	// Data port. Stores take their data from rs2.
	assign daddr  = aluResult;
	assign ddataW = rdDataB;
	assign dRead  = ctl.memRead & rstN;
	assign dWrite = ctl.memWrite & rstN;

	// Next PC.
	assign pcPlus4    = pc + 32'd4;
	assign pcPlusImm  = pc + imm;
	assign takeBranch = ctl.branch & aluZero; // beq with equal operands.
	assign nextPc     = takeBranch ? pcPlusImm : pcPlus4;

	always_ff @(posedge CLK) begin
		if (!rstN) pc <= resetPc;
		else       pc <= nextPc;
	end

	assign iaddr = pc;

endmodule

/* bench/rvCore_assert.sv */
// Port checker for the RV32I core: strobe exclusion, reset state, sequential fetch and alignment.
module rvCoreChecks import rvIsaPkg::*, corePkg::*; (
	input logic CLK,
	input logic rstN,
	input wordT iaddr,
	input wordT idata,
	input wordT daddr,
	input logic dRead,
	input logic dWrite
);

	timeunit 1ns;
	timeprecision 100ps;

	int assertFails = 0; // Number of failed assertions so far.

	// One data access per cycle at most.
	strobeExclusive: assert property (@(posedge CLK) !(dRead && dWrite))
		else begin
			$error("dRead and dWrite are high in the same cycle");
			assertFails++;
		end

	resetStrobes: assert property (@(posedge CLK) !rstN |-> !dRead && !dWrite)
		else begin
			$error("a data strobe is high while rstN is low");
			assertFails++;
		end

	// The PC settles at the reset vector one edge into reset.
	resetFetch: assert property (@(posedge CLK) !rstN ##1 !rstN |-> iaddr == resetPc)
		else begin
			$error("iaddr is not at the reset vector during reset");
			assertFails++;
		end

	firstFetch: assert property (@(posedge CLK) $rose(rstN) |-> iaddr == resetPc)
		else begin
			$error("first fetch after reset is not at address zero");
			assertFails++;
		end

	// Anything but beq moves to the next word.
	seqFetch: assert property (@(posedge CLK)
		rstN && idata[6:0] != opBranch |=> iaddr == $past(iaddr) + 32'd4)
		else begin
			$error("iaddr did not advance by four after a non-branch instruction");
			assertFails++;
		end

	alignedAccess: assert property (@(posedge CLK) dRead || dWrite |-> daddr[1:0] == 2'b00)
		else begin
			$error("data access to an address that is not word aligned");
			assertFails++;
		end

endmodule

bind rvCore rvCoreChecks checks_i (.CLK(CLK), .rstN(rstN), .iaddr(iaddr), .idata(idata),
	.daddr(daddr), .dRead(dRead), .dWrite(dWrite));

/* bench/rvCoreTb.sv */
// Testbench for the single-cycle RV32I core with behavioral instruction and data memories.
module rvCoreTb import rvIsaPkg::*, corePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int   memWords     = 256;
	localparam wordT sentinelAddr = 32'h3FC; // Last store of every program.
	localparam wordT poison       = 32'hBAD0BAD0;

	logic CLK = 1'b0;
	logic rstN;
	wordT iaddr;
	wordT idata;
	wordT daddr;
	wordT ddataW;
	wordT ddataR;
	logic dRead;
	logic dWrite;
	wordT imem [memWords];
	wordT dmem [memWords];
	wordT prog [$];
	wordT expAddr [$];
	wordT expData [$];
	wordT stAddr [$];
	wordT stData [$];
	int   sentinelCount = 0;
	int   passCount = 0;
	int   failCount = 0;

	always #5 CLK = ~CLK;

	rvCore dut_i (.CLK(CLK), .rstN(rstN), .iaddr(iaddr), .idata(idata), .daddr(daddr),
		.ddataW(ddataW), .dRead(dRead), .dWrite(dWrite), .ddataR(ddataR));

	assign idata  = imem[iaddr[9:2]]; // Zero-wait fetch.
	assign ddataR = dRead ? dmem[daddr[9:2]] : 'x; // Load data only during a read.

	// Data memory write port and store log.
	always @(posedge CLK) begin
		if (dWrite) begin
			dmem[daddr[9:2]] <= ddataW;
			if (daddr == sentinelAddr) begin
				sentinelCount <= sentinelCount + 1;
			end else begin
				stAddr.push_back(daddr);
				stData.push_back(ddataW);
			end
		end
	end

	function automatic wordT encR(funct7T f7, funct3T f3, regIdxT rd, regIdxT rs1, regIdxT rs2);
		return {f7, rs2, rs1, f3, rd, opR};
	endfunction

	function automatic wordT encI(opcodeT op, funct3T f3, regIdxT rd, regIdxT rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic wordT encS(regIdxT rs2, regIdxT rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3Sw, imm[4:0], opStore};
	endfunction

	function automatic wordT encB(regIdxT rs1, regIdxT rs2, logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3Beq, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic wordT encU(opcodeT op, regIdxT rd, logic [19:0] upper);
		return {upper, rd, op};
	endfunction

	// Full 32-bit constant. Rounding the upper part cancels the sign of the low twelve bits.
	task automatic loadConst(regIdxT rd, wordT value);
		wordT upper;
		upper = (value + 32'h800) >> 12;
		prog.push_back(encU(opLui, rd, upper[19:0]));
		prog.push_back(encI(opImm, f3AddSub, rd, rd, value[11:0]));
	endtask

	task automatic expectStore(wordT addr, wordT value);
		expAddr.push_back(addr);
		expData.push_back(value);
	endtask

	// Store to an absolute address below 2 KiB, offset from x0.
	task automatic storeAbs(regIdxT rs, wordT addr, wordT value);
		prog.push_back(encS(rs, regZero, addr[11:0]));
		expectStore(addr, value);
	endtask

	task automatic regOpStore(funct7T f7, funct3T f3, wordT value, int slot);
		prog.push_back(encR(f7, f3, 5'd3, 5'd1, 5'd2));
		storeAbs(5'd3, 32'h100 + 4 * slot, value);
	endtask

	task automatic immOpStore(funct3T f3, logic [11:0] imm, wordT value, int slot);
		prog.push_back(encI(opImm, f3, 5'd3, 5'd1, imm));
		storeAbs(5'd3, 32'h100 + 4 * slot, value);
	endtask

	task automatic runTest(string name);
		int cycles;
		int errors;
		int startCount;
		cycles = 0;
		errors = 0;
		prog.push_back(encS(regZero, regZero, sentinelAddr[11:0]));
		@(posedge CLK);
		rstN <= 1'b0;
		@(posedge CLK);
		for (int i = 0; i < memWords; i++) begin
			imem[i] = encI(opImm, f3AddSub, regZero, regZero, 12'(i)); // Nop with an index.
			dmem[i] = 32'hA5000000 | i;
		end
		foreach (prog[i]) imem[i] = prog[i];
		stAddr.delete();
		stData.delete();
		startCount = sentinelCount;
		repeat (15) @(posedge CLK);
		rstN <= 1'b1;
		while (sentinelCount == startCount && cycles < 200) begin
			@(posedge CLK);
			cycles++;
		end
		if (sentinelCount == startCount) begin
			$display("%s: timed out after %0d cycles without the final store", name, cycles);
			errors++;
		end else if (stAddr.size() != expAddr.size()) begin
			$display("error %s: expected %0d stores, actual %0d", name, expAddr.size(),
				stAddr.size());
			errors++;
		end else begin
			foreach (expAddr[i]) begin
				if (stAddr[i] !== expAddr[i] || stData[i] !== expData[i]) begin
					$display("error %s store %0d: expected %h at %h, actual %h at %h", name, i,
						expData[i], expAddr[i], stData[i], stAddr[i]);
					errors++;
				end
			end
		end
		if (errors == 0) begin
			passCount++;
			$display("%s: passed with %0d stores", name, stAddr.size());
		end else begin
			failCount++;
			$display("%s: failed with %0d errors", name, errors);
		end
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	initial begin
		wordT        a;
		wordT        b;
		wordT        base;
		wordT        immExt;
		wordT        pcAuipc;
		logic [11:0] imm;
		logic [4:0]  shamt;
		logic [19:0] upper;
		rstN = 1'b0;
		void'($urandom(32'h015fb226));

		// Straight-line code from address 0.
		for (int k = 0; k < 4; k++) begin
			prog.push_back(encI(opImm, f3AddSub, 5'd1, regZero, 12'(k + 1)));
			storeAbs(5'd1, 32'h80 + 4 * k, k + 1);
		end
		runTest("fetch");

		a = $urandom();
		b = $urandom();
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		regOpStore(f7Base, f3AddSub, a + b, 0);
		regOpStore(f7Alt, f3AddSub, a - b, 1);
		regOpStore(f7Base, f3And, a & b, 2);
		regOpStore(f7Base, f3Or, a | b, 3);
		regOpStore(f7Base, f3Xor, a ^ b, 4);
		regOpStore(f7Base, f3Slt, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, 5);
		regOpStore(f7Base, f3Sltu, (a < b) ? 32'd1 : 32'd0, 6);
		regOpStore(f7Base, f3Sll, a << b[4:0], 7);
		regOpStore(f7Base, f3SrlSra, a >> b[4:0], 8);
		regOpStore(f7Alt, f3SrlSra, $signed(a) >>> b[4:0], 9);
		runTest("regOps");

		a = $urandom();
		imm = 12'($urandom());
		immExt = {{20{imm[11]}}, imm};
		shamt = 5'($urandom());
		loadConst(5'd1, a);
		immOpStore(f3AddSub, imm, a + immExt, 0);
		immOpStore(f3And, imm, a & immExt, 1);
		immOpStore(f3Or, imm, a | immExt, 2);
		immOpStore(f3Xor, imm, a ^ immExt, 3);
		immOpStore(f3Slt, imm, ($signed(a) < $signed(immExt)) ? 32'd1 : 32'd0, 4);
		immOpStore(f3Sll, {f7Base, shamt}, a << shamt, 5);
		immOpStore(f3SrlSra, {f7Base, shamt}, a >> shamt, 6);
		immOpStore(f3SrlSra, {f7Alt, shamt}, $signed(a) >>> shamt, 7);
		prog.push_back(encI(opImm, f3AddSub, regZero, 5'd1, imm)); // Write to x0 is dropped.
		storeAbs(regZero, 32'h120, 32'd0);
		runTest("immOps");

		a = $urandom();
		b = $urandom();
		imm = 12'($urandom());
		immExt = {{20{imm[11]}}, imm};
		base = 32'h240;
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		prog.push_back(encI(opImm, f3AddSub, 5'd5, regZero, base[11:0]));
		prog.push_back(encS(5'd1, 5'd5, 12'(-64)));
		expectStore(base - 64, a);
		prog.push_back(encS(5'd2, 5'd5, 12'(-56)));
		expectStore(base - 56, b);
		prog.push_back(encI(opLoad, f3Lw, 5'd6, 5'd5, 12'(-64)));
		prog.push_back(encI(opLoad, f3Lw, 5'd7, 5'd5, 12'(-56)));
		prog.push_back(encI(opImm, f3AddSub, 5'd6, 5'd6, imm));
		prog.push_back(encI(opImm, f3AddSub, 5'd7, 5'd7, imm));
		prog.push_back(encS(5'd6, 5'd5, 12'(-60)));
		expectStore(base - 60, a + immExt);
		prog.push_back(encS(5'd7, 5'd5, 12'd8));
		expectStore(base + 8, b + immExt);
		runTest("loadStore");

		a = $urandom();
		if (a == poison) begin
			a = ~a;
		end
		upper = 20'($urandom());
		loadConst(5'd1, a);
		prog.push_back(encI(opImm, f3AddSub, 5'd2, 5'd1, 12'd0)); // Copy of x1.
		loadConst(5'd3, poison);
		prog.push_back(encB(5'd1, 5'd2, 13'd8)); // Taken, so the poison store is skipped.
		prog.push_back(encS(5'd3, regZero, 12'h300));
		prog.push_back(encB(5'd1, 5'd3, 13'd8)); // Not taken.
		storeAbs(5'd1, 32'h304, a);
		pcAuipc = wordT'(4 * prog.size());
		prog.push_back(encU(opAuipc, 5'd4, upper));
		storeAbs(5'd4, 32'h308, pcAuipc + {upper, 12'b0});
		prog.push_back(encU(opLui, 5'd6, upper));
		storeAbs(5'd6, 32'h30C, {upper, 12'b0});
		runTest("branchUpper");

		$display("%0d tests passed, %0d failed, %0d assertion failures", passCount, failCount,
			dut_i.checks_i.assertFails);
		if (failCount == 0 && dut_i.checks_i.assertFails == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* rvCore.f */
logic/rvIsaPkg.sv
logic/corePkg.sv
logic/ctrlIf.sv
logic/instrDecoder.sv
logic/immGen.sv
logic/regBank.sv
logic/alu.sv
logic/rvCore.sv
bench/rvCore_assert.sv
bench/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvCore

sources:
  - target: any(rtl, test)
    files:
      - logic/rvIsaPkg.sv
      - logic/corePkg.sv
      - logic/ctrlIf.sv
      - logic/instrDecoder.sv
      - logic/immGen.sv
      - logic/regBank.sv
      - logic/alu.sv
      - logic/rvCore.sv
  - target: test
    files:
      - bench/rvCore_assert.sv
      - bench/rvCoreTb.sv
